//--- hw/kcpu_pkg.sv
//******************************
// shared types for the register-file block
// postbyte is read either as a transfer pair or as an index mode
// pc and dp are not modelled here
//******************************
package kcpu_pkg;

    typedef enum logic [3:0] {
        LOAD  = 4'd0,
        TFR   = 4'd1,
        EXG   = 4'd2,
        LEA   = 4'd3,
        ANDCC = 4'd4,
        ORCC  = 4'd5,
        PUSH  = 4'd6,
        PULL  = 4'd7
    } cmd_op_e;

    // codes 7..15 read as zero and write nothing
    typedef enum logic [3:0] {
        REG_A  = 4'd0,
        REG_B  = 4'd1,
        REG_X  = 4'd2,
        REG_Y  = 4'd3,
        REG_S  = 4'd4,
        REG_U  = 4'd5,
        REG_CC = 4'd6
    } reg_code_e;

    // reserved flag positions in cc
    typedef enum logic [2:0] {
        CC_I = 3'd4,
        CC_F = 3'd6,
        CC_E = 3'd7
    } cc_bit_e;

    typedef struct packed {
        reg_code_e src;
        reg_code_e dst;
    } xfer_pb_t;

    typedef struct packed {
        logic       pad_hi;
        logic [1:0] base;   // x, y, u, s
        logic       pad_lo;
        logic [1:0] step;   // 2 is -1, 3 is -2, else none
        logic [1:0] dst;    // x, y, u, s
    } idx_pb_t;

    typedef union packed {
        xfer_pb_t xfer;
        idx_pb_t  idx;
    } postbyte_u;

    typedef struct packed {
        cmd_op_e    op;
        reg_code_e  reg_sel;  // load target
        postbyte_u  pb;
        logic [15:0] imm;     // low byte is the push/pull mask
        logic       use_u;
    } kcpu_cmd_t;

    typedef struct packed {
        logic [7:0]  a;
        logic [7:0]  b;
        logic [7:0]  cc;
        logic [15:0] x;
        logic [15:0] y;
        logic [15:0] u;
        logic [15:0] s;
    } reg_state_t;

    typedef struct packed {
        cmd_op_e    op;
        reg_state_t regs;
    } kcpu_rsp_t;

endpackage

//--- hw/kcpu_stack_ram.sv
//******************************
// byte-wide stack memory, read data one cycle after address
// contents are not cleared by reset
//******************************
`timescale 1ns/1ps

module kcpu_stack_ram #(
    parameter int depth = 256
) (
    input  logic       clk,
    input  logic [7:0] addr,
    input  logic       we,
    input  logic [7:0] wdata,
    output logic [7:0] rdata
);

    logic [7:0] mem [0:depth-1];

    always_ff @(posedge clk) begin
        if (we)
            mem[addr] <= wdata;
        rdata <= mem[addr];   // old data on a same-address write
    end

endmodule

//--- hw/kcpu_stack_seq.sv
//******************************
// push/pull sequencer, mask bits 3 and 7 are dropped
// push is one byte per cycle, pull takes two (registered ram read)
//******************************
`timescale 1ns/1ps

module kcpu_stack_seq (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic [7:0]  mask,
    input  logic        is_pull,
    output logic [7:0]  psh_sel,
    output logic        psh_hilon,
    output logic        pshdec,
    output logic        pul_en,
    output logic [7:0]  pul_data,
    output logic [7:0]  ram_addr,
    output logic        ram_we,
    output logic [7:0]  ram_wdata,
    input  logic [7:0]  ram_rdata,
    input  logic [7:0]  psh_mux,
    input  logic [15:0] psh_addr,
    output logic        done
);

    logic [7:0] rem, cur, rem_nx, mask_eff;
    logic       pull_q, second, rd_phase;
    logic       busy, wide, last, step;

    assign mask_eff = mask & 8'h77;   // no pc, no dp
    assign busy     = |rem;

    // pull walks up from bit 0, push walks down from bit 7
    always_comb begin
        cur = 8'h00;
        if (pull_q)
            cur = rem & (~rem + 8'd1);
        else
            for (int i = 0; i < 8; i++)
                if (rem[i]) cur = 8'd1 << i;
    end

    assign wide   = |(cur & 8'h70);     // x, y, other pointer
    assign last   = !wide || second;
    assign rem_nx = rem & ~cur;
    assign step   = busy && (!pull_q || rd_phase);

    assign psh_sel   = cur;
    assign psh_hilon = wide && (pull_q ? !second : second);
    assign pshdec    = busy && !pull_q;
    assign pul_en    = busy && pull_q && rd_phase;
    assign pul_data  = ram_rdata;
    assign ram_we    = pshdec;
    assign ram_wdata = psh_mux;
    assign ram_addr  = pshdec ? psh_addr[7:0] - 8'd1 : psh_addr[7:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rem      <= 8'h00;
            pull_q   <= 1'b0;
            second   <= 1'b0;
            rd_phase <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                rem      <= mask_eff;
                pull_q   <= is_pull;
                second   <= 1'b0;
                rd_phase <= 1'b0;
                done     <= mask_eff == 8'h00;   // nothing to move
            end else if (busy) begin
                if (pull_q)
                    rd_phase <= !rd_phase;       // address cycle, then data
                if (step && last) begin
                    rem    <= rem_nx;
                    second <= 1'b0;
                    done   <= rem_nx == 8'h00;
                end else if (step) begin
                    second <= 1'b1;
                end
            end
        end
    end

endmodule

//--- hw/kcpu_regs.sv
//******************************
// programmer registers a, b, x, y, u, s and cc
// 8-bit registers read zero-extended, 16-bit writes keep the low byte
// only one update strobe is expected per cycle
//******************************
`timescale 1ns/1ps

module kcpu_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  up_load,
    input  kcpu_pkg::reg_code_e   reg_sel,
    input  logic [15:0]           imm,
    input  logic                  up_tfr,
    input  logic                  up_exg,
    input  logic                  up_lea,
    input  logic                  up_andcc,
    input  logic                  up_orcc,
    input  kcpu_pkg::postbyte_u   pb,
    input  logic [7:0]            psh_sel,
    input  logic                  psh_hilon,
    input  logic                  psh_ussel,
    input  logic                  pshdec,
    input  logic                  pul_en,
    input  logic [7:0]            pul_data,
    output logic [7:0]            psh_mux,
    output logic [15:0]           psh_addr,
    output kcpu_pkg::reg_state_t  state
);

    kcpu_pkg::reg_state_t q, nx;
    logic [15:0] src_val, dst_val;
    logic [15:0] base_val, step_amt, lea_val;
    logic [15:0] psh_other;

    function automatic logic [15:0] get(input kcpu_pkg::reg_state_t r,
                                        input kcpu_pkg::reg_code_e code);
        case (code)
            kcpu_pkg::REG_A:  return {8'h00, r.a};
            kcpu_pkg::REG_B:  return {8'h00, r.b};
            kcpu_pkg::REG_X:  return r.x;
            kcpu_pkg::REG_Y:  return r.y;
            kcpu_pkg::REG_S:  return r.s;
            kcpu_pkg::REG_U:  return r.u;
            kcpu_pkg::REG_CC: return {8'h00, r.cc};
            default:          return 16'h0000;
        endcase
    endfunction

    function automatic kcpu_pkg::reg_state_t put(input kcpu_pkg::reg_state_t r,
                                                 input kcpu_pkg::reg_code_e code,
                                                 input logic [15:0] val);
        kcpu_pkg::reg_state_t o;
        o = r;
        case (code)
            kcpu_pkg::REG_A:  o.a  = val[7:0];
            kcpu_pkg::REG_B:  o.b  = val[7:0];
            kcpu_pkg::REG_X:  o.x  = val;
            kcpu_pkg::REG_Y:  o.y  = val;
            kcpu_pkg::REG_S:  o.s  = val;
            kcpu_pkg::REG_U:  o.u  = val;
            kcpu_pkg::REG_CC: o.cc = val[7:0];
            default: ;        // invalid code, no write
        endcase
        return o;
    endfunction

    // 2-bit index register field to register code
    function automatic kcpu_pkg::reg_code_e idx_code(input logic [1:0] sel);
        case (sel)
            2'd0:    return kcpu_pkg::REG_X;
            2'd1:    return kcpu_pkg::REG_Y;
            2'd2:    return kcpu_pkg::REG_U;
            default: return kcpu_pkg::REG_S;
        endcase
    endfunction

    assign state     = q;
    assign psh_addr  = psh_ussel ? q.u : q.s;
    assign psh_other = psh_ussel ? q.s : q.u;   // mask bit 6

    // transfer view of the postbyte
    assign src_val = get(q, pb.xfer.src);
    assign dst_val = get(q, pb.xfer.dst);

    // index view of the same byte
    assign base_val = get(q, idx_code(pb.idx.base));
    assign step_amt = (pb.idx.step == 2'd2) ? 16'd1 :
                      (pb.idx.step == 2'd3) ? 16'd2 : 16'd0;
    assign lea_val  = base_val - step_amt;

    always_comb begin
        casez (psh_sel)
            8'b????_???1: psh_mux = q.cc;
            8'b????_??10: psh_mux = q.a;
            8'b????_?100: psh_mux = q.b;
            8'b???1_0000: psh_mux = psh_hilon ? q.x[15:8] : q.x[7:0];
            8'b??10_0000: psh_mux = psh_hilon ? q.y[15:8] : q.y[7:0];
            8'b?100_0000: psh_mux = psh_hilon ? psh_other[15:8] : psh_other[7:0];
            default:      psh_mux = 8'h00;
        endcase
    end

    always_comb begin
        nx = q;
        if (up_load)
            nx = put(nx, reg_sel, imm);
        if (up_tfr || up_exg)
            nx = put(nx, pb.xfer.dst, src_val);
        if (up_exg)
            nx = put(nx, pb.xfer.src, dst_val);   // second half of the swap
        if (up_lea)
            nx = put(nx, idx_code(pb.idx.dst), lea_val);
        if (up_andcc)
            nx.cc = q.cc & imm[7:0];
        if (up_orcc)
            nx.cc = q.cc | imm[7:0];

        // stack pointer moves before the byte lands
        if (pshdec) begin
            if (psh_ussel) nx.u = q.u - 16'd1;
            else           nx.s = q.s - 16'd1;
        end
        if (pul_en) begin
            if (psh_ussel) nx.u = q.u + 16'd1;
            else           nx.s = q.s + 16'd1;
            casez (psh_sel)
                8'b????_???1: nx.cc = pul_data;
                8'b????_??10: nx.a  = pul_data;
                8'b????_?100: nx.b  = pul_data;
                8'b???1_0000: begin
                    if (psh_hilon) nx.x[15:8] = pul_data;
                    else           nx.x[7:0]  = pul_data;
                end
                8'b??10_0000: begin
                    if (psh_hilon) nx.y[15:8] = pul_data;
                    else           nx.y[7:0]  = pul_data;
                end
                8'b?100_0000: begin
                    if (psh_ussel && psh_hilon)       nx.s[15:8] = pul_data;
                    else if (psh_ussel)               nx.s[7:0]  = pul_data;
                    else if (psh_hilon)               nx.u[15:8] = pul_data;
                    else                              nx.u[7:0]  = pul_data;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            q <= '0;
        else
            q <= nx;
    end

endmodule

//--- hw/kcpu_ctrl.sv
//******************************
// command decode and valid/ready handshake
// one command in flight, next one waits for the response to leave
//******************************
`timescale 1ns/1ps

module kcpu_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  kcpu_pkg::kcpu_cmd_t   cmd,
    output logic                  rsp_valid,
    input  logic                  rsp_ready,
    output kcpu_pkg::kcpu_rsp_t   rsp,
    input  kcpu_pkg::reg_state_t  state,
    output logic                  up_load,
    output kcpu_pkg::reg_code_e   reg_sel,
    output logic [15:0]           imm,
    output logic                  up_tfr,
    output logic                  up_exg,
    output logic                  up_lea,
    output logic                  up_andcc,
    output logic                  up_orcc,
    output kcpu_pkg::postbyte_u   pb,
    output logic                  start,
    output logic                  is_pull,
    output logic [7:0]            mask,
    output logic                  use_u,
    input  logic                  done
);

    typedef enum logic [1:0] {IDLE, STACK, RESPOND} ctrl_st_e;

    ctrl_st_e          st;
    kcpu_pkg::cmd_op_e op_q;
    logic              accept, stack_op;

    assign cmd_ready = st == IDLE;
    assign rsp_valid = st == RESPOND;
    assign accept    = cmd_valid && cmd_ready;
    assign stack_op  = cmd.op == kcpu_pkg::PUSH || cmd.op == kcpu_pkg::PULL;

    // simple ops update the registers on the accept edge
    assign up_load  = accept && cmd.op == kcpu_pkg::LOAD;
    assign up_tfr   = accept && cmd.op == kcpu_pkg::TFR;
    assign up_exg   = accept && cmd.op == kcpu_pkg::EXG;
    assign up_lea   = accept && cmd.op == kcpu_pkg::LEA;
    assign up_andcc = accept && cmd.op == kcpu_pkg::ANDCC;
    assign up_orcc  = accept && cmd.op == kcpu_pkg::ORCC;
    assign start    = accept && stack_op;
    assign reg_sel  = cmd.reg_sel;
    assign imm      = cmd.imm;
    assign pb       = cmd.pb;
    assign mask     = cmd.imm[7:0];     // sampled with start only
    assign is_pull  = cmd.op == kcpu_pkg::PULL;

    always_comb begin
        rsp.op   = op_q;
        rsp.regs = state;    // registers are frozen outside accept and stack
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st    <= IDLE;
            op_q  <= kcpu_pkg::LOAD;
            use_u <= 1'b0;
        end else begin
            case (st)
                IDLE: if (accept) begin
                    op_q  <= cmd.op;
                    use_u <= cmd.use_u;   // stack select for the whole walk
                    st    <= stack_op ? STACK : RESPOND;
                end
                STACK:   if (done) st <= RESPOND;
                RESPOND: if (rsp_ready) st <= IDLE;
                default: st <= IDLE;
            endcase
        end
    end

endmodule

//--- hw/kcpu_regs_top.sv
//******************************
// register file with stack engine behind a command port
// stack ram sees only the low byte of the stack pointer
//******************************
`timescale 1ns/1ps

module kcpu_regs_top #(
    parameter int depth = 256
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cmd_valid,
    output logic                 cmd_ready,
    input  kcpu_pkg::kcpu_cmd_t  cmd,
    output logic                 rsp_valid,
    input  logic                 rsp_ready,
    output kcpu_pkg::kcpu_rsp_t  rsp
);

    kcpu_pkg::reg_state_t state;
    kcpu_pkg::reg_code_e  reg_sel;
    kcpu_pkg::postbyte_u  pb;
    logic [15:0] imm, psh_addr;
    logic        up_load, up_tfr, up_exg, up_lea, up_andcc, up_orcc;
    logic        start, is_pull, use_u, done;
    logic [7:0]  mask, psh_sel, psh_mux, pul_data;
    logic        psh_hilon, pshdec, pul_en;
    logic [7:0]  ram_addr, ram_wdata, ram_rdata;
    logic        ram_we;

    kcpu_ctrl u_ctrl (
        .clk, .rst, .cmd_valid, .cmd_ready, .cmd, .rsp_valid, .rsp_ready, .rsp,
        .state, .up_load, .reg_sel, .imm, .up_tfr, .up_exg, .up_lea, .up_andcc,
        .up_orcc, .pb, .start, .is_pull, .mask, .use_u, .done
    );

    kcpu_regs u_regs (
        .clk, .rst, .up_load, .reg_sel, .imm, .up_tfr, .up_exg, .up_lea, .up_andcc,
        .up_orcc, .pb, .psh_sel, .psh_hilon, .psh_ussel(use_u), .pshdec, .pul_en,
        .pul_data, .psh_mux, .psh_addr, .state
    );

    kcpu_stack_seq u_seq (
        .clk, .rst, .start, .mask, .is_pull, .psh_sel, .psh_hilon, .pshdec, .pul_en,
        .pul_data, .ram_addr, .ram_we, .ram_wdata, .ram_rdata, .psh_mux, .psh_addr,
        .done
    );

    kcpu_stack_ram #(.depth(depth)) u_ram (
        .clk, .addr(ram_addr), .we(ram_we), .wdata(ram_wdata), .rdata(ram_rdata)
    );

endmodule

//--- bench/kcpu_regs_tb.sv
//******************************
// random command testbench with a register and stack model
// stack ram is filled by pushes before the random run
// stops at the first mismatch
//******************************
`timescale 1ns/1ps

module kcpu_regs_tb;

    localparam int num_cmds    = 400;
    localparam int fill_rounds = 29;   // 29 pushes of 9 bytes cover all 256 bytes
    localparam int max_cycles  = (num_cmds + 2 * fill_rounds + 2) * 40;

    logic                 clk;
    logic                 rst;
    logic                 cmd_valid;
    logic                 cmd_ready;
    kcpu_pkg::kcpu_cmd_t  cmd;
    logic                 rsp_valid;
    logic                 rsp_ready;
    kcpu_pkg::kcpu_rsp_t  rsp;

    kcpu_pkg::reg_state_t m;            // model registers
    kcpu_pkg::reg_state_t last_regs;
    logic [7:0]           stack_mem [0:255];
    int                   cycles = 0;

    kcpu_regs_top #(.depth(256)) dut (
        .clk, .rst, .cmd_valid, .cmd_ready, .cmd, .rsp_valid, .rsp_ready, .rsp
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > max_cycles) begin
            $display("timeout: no response within %0d cycles", max_cycles);
            $display("test failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic compare(input string what, input logic [95:0] got,
                           input logic [95:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // register codes 0 a, 1 b, 2 x, 3 y, 4 s, 5 u, 6 cc
    function automatic logic [15:0] read_reg(input logic [3:0] code);
        case (code)
            4'd0:    return {8'h00, m.a};
            4'd1:    return {8'h00, m.b};
            4'd2:    return m.x;
            4'd3:    return m.y;
            4'd4:    return m.s;
            4'd5:    return m.u;
            4'd6:    return {8'h00, m.cc};
            default: return 16'h0000;
        endcase
    endfunction

    task automatic write_reg(input logic [3:0] code, input logic [15:0] val);
        case (code)
            4'd0:    m.a  = val[7:0];
            4'd1:    m.b  = val[7:0];
            4'd2:    m.x  = val;
            4'd3:    m.y  = val;
            4'd4:    m.s  = val;
            4'd5:    m.u  = val;
            4'd6:    m.cc = val[7:0];
            default: ;
        endcase
    endtask

    // lea field order is x, y, u, s
    function automatic logic [3:0] idx_reg(input logic [1:0] sel);
        case (sel)
            2'd0:    return 4'd2;
            2'd1:    return 4'd3;
            2'd2:    return 4'd5;
            default: return 4'd4;
        endcase
    endfunction

    // mask bit to register code with bit 6 as the other stack pointer
    function automatic logic [3:0] mask_reg(input int bitpos, input logic use_u);
        case (bitpos)
            0:       return 4'd6;
            1:       return 4'd0;
            2:       return 4'd1;
            4:       return 4'd2;
            5:       return 4'd3;
            default: return use_u ? 4'd4 : 4'd5;
        endcase
    endfunction

    task automatic stack_push(input logic [7:0] mask, input logic use_u);
        logic [15:0] sp;
        logic [15:0] val;
        sp = use_u ? m.u : m.s;
        for (int i = 7; i >= 0; i--) begin
            if (mask[i] && i != 3 && i != 7) begin
                val = read_reg(mask_reg(i, use_u));
                sp = sp - 16'd1;
                stack_mem[sp[7:0]] = val[7:0];      // low byte first
                if (i >= 4) begin
                    sp = sp - 16'd1;
                    stack_mem[sp[7:0]] = val[15:8];
                end
            end
        end
        if (use_u) m.u = sp;
        else       m.s = sp;
    endtask

    task automatic stack_pull(input logic [7:0] mask, input logic use_u);
        logic [15:0] sp;
        logic [15:0] val;
        sp = use_u ? m.u : m.s;
        for (int i = 0; i < 8; i++) begin
            if (mask[i] && i != 3 && i != 7) begin
                val = {8'h00, stack_mem[sp[7:0]]};
                sp = sp + 16'd1;
                if (i >= 4) begin
                    val = {val[7:0], stack_mem[sp[7:0]]};   // high came first
                    sp = sp + 16'd1;
                end
                write_reg(mask_reg(i, use_u), val);
            end
        end
        if (use_u) m.u = sp;
        else       m.s = sp;
    endtask

    task automatic apply_cmd(input kcpu_pkg::kcpu_cmd_t c);
        logic [7:0]  pbv;
        logic [15:0] sv;
        logic [15:0] dv;
        pbv = c.pb;
        sv  = read_reg(pbv[7:4]);
        dv  = read_reg(pbv[3:0]);
        case (c.op)
            kcpu_pkg::LOAD:  write_reg(c.reg_sel, c.imm);
            kcpu_pkg::TFR:   write_reg(pbv[3:0], sv);
            kcpu_pkg::EXG: begin
                write_reg(pbv[3:0], sv);
                write_reg(pbv[7:4], dv);
            end
            kcpu_pkg::LEA: begin
                sv = read_reg(idx_reg(pbv[6:5]));
                if (pbv[3:2] == 2'd2)      sv = sv - 16'd1;
                else if (pbv[3:2] == 2'd3) sv = sv - 16'd2;
                write_reg(idx_reg(pbv[1:0]), sv);
            end
            kcpu_pkg::ANDCC: m.cc = m.cc & c.imm[7:0];
            kcpu_pkg::ORCC:  m.cc = m.cc | c.imm[7:0];
            kcpu_pkg::PUSH:  stack_push(c.imm[7:0], c.use_u);
            default:         stack_pull(c.imm[7:0], c.use_u);
        endcase
    endtask

    // cmd_valid stays high until the response leaves so a second accept would show
    task automatic run_cmd(input kcpu_pkg::kcpu_cmd_t c);
        kcpu_pkg::kcpu_rsp_t held;
        logic                seen;
        logic                finished;
        @(negedge clk);
        rsp_ready = 1'b0;
        cmd       = c;
        cmd_valid = 1'b1;
        while (!cmd_ready)
            @(negedge clk);
        apply_cmd(c);
        seen     = 1'b0;
        finished = 1'b0;
        while (!finished) begin
            @(negedge clk);
            compare("cmd_ready while busy", cmd_ready, 1'b0);
            if (rsp_valid) begin
                if (!seen) begin
                    compare("rsp.op", rsp.op, c.op);
                    compare("rsp.a", rsp.regs.a, m.a);
                    compare("rsp.b", rsp.regs.b, m.b);
                    compare("rsp.cc", rsp.regs.cc, m.cc);
                    compare("rsp.x", rsp.regs.x, m.x);
                    compare("rsp.y", rsp.regs.y, m.y);
                    compare("rsp.u", rsp.regs.u, m.u);
                    compare("rsp.s", rsp.regs.s, m.s);
                    held = rsp;
                    seen = 1'b1;
                end else begin
                    compare("rsp held under back-pressure", rsp, held);
                end
                rsp_ready = ($urandom % 3) != 0;   // stall about a third of cycles
                if (rsp_ready) begin
                    cmd_valid = 1'b0;
                    finished  = 1'b1;
                end
            end
        end
        last_regs = held.regs;
    endtask

    function automatic kcpu_pkg::kcpu_cmd_t random_cmd();
        kcpu_pkg::kcpu_cmd_t c;
        logic [3:0] src;
        logic [3:0] dst;
        c         = '0;
        c.op      = kcpu_pkg::cmd_op_e'($urandom % 8);
        c.reg_sel = kcpu_pkg::reg_code_e'($urandom % 10);   // 7..9 invalid
        c.imm     = 16'($urandom);
        c.use_u   = 1'($urandom);
        src       = 4'($urandom % 9);
        dst       = 4'($urandom % 9);
        if (c.op == kcpu_pkg::TFR || c.op == kcpu_pkg::EXG)
            c.pb = {src, dst};
        else
            c.pb = 8'($urandom);
        return c;
    endfunction

    initial begin
        kcpu_pkg::kcpu_cmd_t  c;
        kcpu_pkg::kcpu_cmd_t  pair_cmd;
        kcpu_pkg::reg_state_t snapshot;
        logic                 pair_pending;
        logic                 is_pair;
        int                   code;
        void'($urandom(32'hb3d7));
        rst          = 1'b1;
        cmd_valid    = 1'b0;
        cmd          = '0;
        rsp_ready    = 1'b0;
        m            = '0;
        pair_pending = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        compare("cmd_ready after reset", cmd_ready, 1'b1);
        compare("rsp_valid after reset", rsp_valid, 1'b0);
        compare("registers after reset", rsp.regs, '0);

        // fill the stack ram as s walks down 9 bytes per push
        for (int k = 0; k < fill_rounds; k++) begin
            code = $urandom % 6;
            if (code == 4)
                code = 6;                  // keep s untouched
            c         = '0;
            c.op      = kcpu_pkg::LOAD;
            c.reg_sel = kcpu_pkg::reg_code_e'(code);
            c.imm     = 16'($urandom);
            run_cmd(c);
            c      = '0;
            c.op   = kcpu_pkg::PUSH;
            c.imm  = 16'h00ff;
            run_cmd(c);
        end

        for (int n = 0; n < num_cmds; n++) begin
            if (pair_pending) begin
                c            = pair_cmd;
                c.op         = kcpu_pkg::PULL;
                pair_pending = 1'b0;
                is_pair      = 1'b1;
            end else begin
                c       = random_cmd();
                is_pair = 1'b0;
            end
            if (c.op == kcpu_pkg::PUSH) begin
                snapshot = m;
                if ($urandom % 2) begin
                    pair_pending = 1'b1;
                    pair_cmd     = c;
                end
            end
            run_cmd(c);
            if (is_pair)
                compare("push then pull restores state", last_regs, snapshot);
        end

        @(negedge clk);
        $display("test passed");
        $finish;
    end

endmodule

//--- compile.f
hw/kcpu_pkg.sv
hw/kcpu_stack_ram.sv
hw/kcpu_stack_seq.sv
hw/kcpu_regs.sv
hw/kcpu_ctrl.sv
hw/kcpu_regs_top.sv
bench/kcpu_regs_tb.sv
